//--- design/sram_adapter_pkg.sv
////////////////////////////////////////////////////////////
// Bus and SRAM widths, TL-UL opcodes, blanking data and
// the payload types carried by the adapter FIFOs
////////////////////////////////////////////////////////////
`default_nettype none

package sram_adapter_pkg;

  // Bus geometry
  localparam int TlDw  = 32;
  localparam int TlDbw = TlDw / 8;
  localparam int TlAw  = 32;
  localparam int TlSzw = 2;
  localparam int TlAiw = 8;

  // SRAM geometry with two bus words per SRAM word
  localparam int SramDw    = 64;
  localparam int WidthMult = SramDw / TlDw;
  localparam int SramAw    = 10;

  // Depth of every FIFO and so the limit on unanswered requests
  localparam int Outstanding = 2;

  // A-channel opcodes
  localparam logic [2:0] OpGet        = 3'h4;
  localparam logic [2:0] OpPutFull    = 3'h0;
  localparam logic [2:0] OpPutPartial = 3'h1;

  // D-channel opcodes
  localparam logic [2:0] OpAccessAck     = 3'h0;
  localparam logic [2:0] OpAccessAckData = 3'h1;

  // Returned in place of data on a failed access
  localparam logic [TlDw-1:0] DataWhenError      = 32'hffff_ffff;
  localparam logic [TlDw-1:0] DataWhenInstrError = 32'h0bad_f00d;

  typedef enum logic {
    OpWrite = 1'b0,
    OpRead  = 1'b1
  } req_op_e;

  // Response context of one accepted request
  typedef struct packed {
    req_op_e          op;
    logic             error;
    logic             instr;
    logic [TlSzw-1:0] size;
    logic [TlAiw-1:0] source;
  } req_ctx_t;

  // Byte mask and SRAM half of one pending read
  typedef struct packed {
    logic [TlDbw-1:0]             mask;
    logic [$clog2(WidthMult)-1:0] woffset;
  } sram_rd_ctx_t;

  // Bus word returned by the SRAM with its uncorrectable flag
  typedef struct packed {
    logic [TlDw-1:0] data;
    logic            error;
  } rsp_data_t;

endpackage

`default_nettype wire

//--- design/adapter_fifo.sv
////////////////////////////////////////////////////////////
// Synchronous FIFO with a typed payload and pass-through
////////////////////////////////////////////////////////////
`timescale 1ns/1ps
`default_nettype none

module adapter_fifo #(
  parameter type payload_t = logic,
  parameter bit  Pass      = 1'b0
) (
  input  logic     clk_i,
  input  logic     rst_ni,
  input  logic     wvalid_i,
  output logic     wready_o,
  input  payload_t wdata_i,
  output logic     rvalid_o,
  input  logic     rready_i,
  output payload_t rdata_o
);

  // Entry storage
  payload_t mem_q [sram_adapter_pkg::Outstanding];

  logic [$clog2(sram_adapter_pkg::Outstanding)-1:0]   wptr_q, rptr_q;
  logic [$clog2(sram_adapter_pkg::Outstanding+1)-1:0] count_q;

  logic empty, full, bypass, do_push, do_pop;

  assign empty = (count_q == '0);
  assign full  = (count_q == sram_adapter_pkg::Outstanding);

  // In pass mode an empty FIFO forwards the write side directly
  assign bypass = Pass & empty;

  assign wready_o = ~full;
  assign rvalid_o = bypass ? wvalid_i : ~empty;
  assign rdata_o  = bypass ? wdata_i : mem_q[rptr_q];

  // A bypassed entry taken in the same cycle is never stored
  assign do_push = wvalid_i & ~full & ~(bypass & rready_i);
  assign do_pop  = rready_i & ~empty;

  always_ff @(posedge clk_i) begin
    if (do_push) begin
      mem_q[wptr_q] <= wdata_i;
    end
  end

  always_ff @(posedge clk_i or negedge rst_ni) begin
    if (!rst_ni) begin
      wptr_q  <= '0;
      rptr_q  <= '0;
      count_q <= '0;
    end else begin
      if (do_push) begin
        wptr_q <= (wptr_q == sram_adapter_pkg::Outstanding - 1) ? '0 : wptr_q + 1'b1;
      end
      if (do_pop) begin
        rptr_q <= (rptr_q == sram_adapter_pkg::Outstanding - 1) ? '0 : rptr_q + 1'b1;
      end
      // Occupancy only moves when exactly one side acts
      if (do_push && !do_pop) begin
        count_q <= count_q + 1'b1;
      end else if (do_pop && !do_push) begin
        count_q <= count_q - 1'b1;
      end
    end
  end

endmodule

`default_nettype wire

//--- design/tl_req_intake.sv
////////////////////////////////////////////////////////////
// A-channel intake: request checks, SRAM request and
// write lane placement, request-order context FIFO
////////////////////////////////////////////////////////////
`timescale 1ns/1ps
`default_nettype none

module tl_req_intake (
  input  logic                                  clk_i,
  input  logic                                  rst_ni,
  // A channel
  input  logic                                  a_valid_i,
  input  logic [2:0]                            a_opcode_i,
  input  logic [sram_adapter_pkg::TlSzw-1:0]    a_size_i,
  input  logic [sram_adapter_pkg::TlDbw-1:0]    a_mask_i,
  input  logic [sram_adapter_pkg::TlAw-1:0]     a_address_i,
  input  logic [sram_adapter_pkg::TlAiw-1:0]    a_source_i,
  input  logic [sram_adapter_pkg::TlDw-1:0]     a_data_i,
  input  logic                                  a_instr_i,
  output logic                                  a_ready_o,
  input  logic                                  en_ifetch_i,
  // SRAM request side
  output logic                                  req_o,
  input  logic                                  gnt_i,
  output logic                                  we_o,
  output logic [sram_adapter_pkg::SramAw-1:0]   addr_o,
  output logic [sram_adapter_pkg::SramDw-1:0]   wdata_o,
  output logic [sram_adapter_pkg::SramDw-1:0]   wmask_o,
  // Request-order context toward the response side
  output logic                                  ctx_valid_o,
  output sram_adapter_pkg::req_ctx_t            ctx_o,
  input  logic                                  ctx_pop_i,
  // Read context toward the data aligner
  output logic                                  rd_ctx_push_o,
  output sram_adapter_pkg::sram_rd_ctx_t        rd_ctx_o,
  input  logic                                  rd_ctx_ready_i
);

  logic op_err, size_err, align_err, instr_err, req_err;
  logic is_write;
  logic ctx_wready;
  logic [$clog2(sram_adapter_pkg::WidthMult)-1:0] woffset;
  sram_adapter_pkg::req_ctx_t ctx_wdata;

  // Only Get, PutFullData and PutPartialData are served
  assign is_write = (a_opcode_i == sram_adapter_pkg::OpPutFull) ||
                    (a_opcode_i == sram_adapter_pkg::OpPutPartial);
  assign op_err   = ~is_write & (a_opcode_i != sram_adapter_pkg::OpGet);

  // Accesses wider than one bus word are not allowed
  assign size_err = (a_size_i > 2'd2);

  // Address must be aligned to the access size
  always_comb begin
    case (a_size_i)
      2'd1:    align_err = a_address_i[0];
      2'd2:    align_err = |a_address_i[1:0];
      default: align_err = 1'b0;
    endcase
  end

  // Fetch is refused while instruction fetch is disabled
  assign instr_err = a_instr_i & ~en_ifetch_i;

  assign req_err = op_err | size_err | align_err | instr_err;

  // Both context FIFOs need room before anything goes out
  assign req_o     = a_valid_i & ~req_err & ctx_wready & rd_ctx_ready_i;
  // Errored requests complete here without waiting for a grant
  assign a_ready_o = ctx_wready & rd_ctx_ready_i & (req_err | gnt_i);

  assign we_o   = is_write;
  // Bits 12:3 pick the SRAM word and bit 2 picks its half
  assign addr_o = a_address_i[$clog2(sram_adapter_pkg::SramDw / 8) +: sram_adapter_pkg::SramAw];
  assign woffset = a_address_i[$clog2(sram_adapter_pkg::TlDbw) +:
                               $clog2(sram_adapter_pkg::WidthMult)];

  // Place mask and data into the addressed half and leave other bytes zero
  always_comb begin
    wmask_o = '0;
    wdata_o = '0;
    for (int b = 0; b < sram_adapter_pkg::TlDbw; b++) begin
      wmask_o[woffset*sram_adapter_pkg::TlDw + 8*b +: 8] = {8{a_mask_i[b]}};
      wdata_o[woffset*sram_adapter_pkg::TlDw + 8*b +: 8] =
        a_mask_i[b] ? a_data_i[8*b +: 8] : 8'h00;
    end
  end

  // Unsupported opcodes are answered as writes with AccessAck
  assign ctx_wdata = '{
    op:     (a_opcode_i == sram_adapter_pkg::OpGet) ? sram_adapter_pkg::OpRead
                                                    : sram_adapter_pkg::OpWrite,
    error:  req_err,
    instr:  a_instr_i,
    size:   a_size_i,
    source: a_source_i
  };

  // Read context only for reads the SRAM actually took
  assign rd_ctx_push_o = req_o & gnt_i & ~is_write;
  assign rd_ctx_o      = '{mask: a_mask_i, woffset: woffset};

  // One entry per accepted request until its response completes
  adapter_fifo #(
    .payload_t (sram_adapter_pkg::req_ctx_t),
    .Pass      (1'b0)
  ) u_req_fifo (
    .clk_i    (clk_i),
    .rst_ni   (rst_ni),
    .wvalid_i (a_valid_i & a_ready_o),
    .wready_o (ctx_wready),
    .wdata_i  (ctx_wdata),
    .rvalid_o (ctx_valid_o),
    .rready_i (ctx_pop_i),
    .rdata_o  (ctx_o)
  );

endmodule

`default_nettype wire

//--- design/sram_rdata_align.sv
////////////////////////////////////////////////////////////
// Read data path: pending read contexts, half select,
// byte masking and the pass-through response data FIFO
////////////////////////////////////////////////////////////
`timescale 1ns/1ps
`default_nettype none

module sram_rdata_align (
  input  logic                                clk_i,
  input  logic                                rst_ni,
  // Read context from the intake side
  input  logic                                rd_ctx_push_i,
  input  sram_adapter_pkg::sram_rd_ctx_t      rd_ctx_i,
  output logic                                rd_ctx_ready_o,
  // SRAM read return
  input  logic [sram_adapter_pkg::SramDw-1:0] rdata_i,
  input  logic                                rvalid_i,
  input  logic                                rerror_i,
  // Response data toward the D channel
  output logic                                rsp_valid_o,
  output sram_adapter_pkg::rsp_data_t         rsp_o,
  input  logic                                rsp_pop_i
);

  logic rd_ctx_valid;
  logic rsp_wvalid;
  sram_adapter_pkg::sram_rd_ctx_t rd_ctx_head;
  sram_adapter_pkg::rsp_data_t    rsp_wdata;
  logic [sram_adapter_pkg::TlDw-1:0] word_sel, byte_mask;

  // Context of each granted read until its data returns
  adapter_fifo #(
    .payload_t (sram_adapter_pkg::sram_rd_ctx_t),
    .Pass      (1'b0)
  ) u_rd_ctx_fifo (
    .clk_i    (clk_i),
    .rst_ni   (rst_ni),
    .wvalid_i (rd_ctx_push_i),
    .wready_o (rd_ctx_ready_o),
    .wdata_i  (rd_ctx_i),
    .rvalid_o (rd_ctx_valid),
    .rready_i (rvalid_i),
    .rdata_o  (rd_ctx_head)
  );

  // Pick the bus word out of the SRAM word
  assign word_sel = rdata_i[rd_ctx_head.woffset*sram_adapter_pkg::TlDw +: sram_adapter_pkg::TlDw];

  // Expand byte mask to bit mask
  always_comb begin
    byte_mask = '0;
    for (int b = 0; b < sram_adapter_pkg::TlDbw; b++) begin
      byte_mask[8*b +: 8] = {8{rd_ctx_head.mask[b]}};
    end
  end

  assign rsp_wvalid = rvalid_i & rd_ctx_valid;
  assign rsp_wdata  = '{data: word_sel & byte_mask, error: rerror_i};

  // The SRAM has no back-pressure and Outstanding bounds the occupancy
  // so the write side is always ready when data returns
  adapter_fifo #(
    .payload_t (sram_adapter_pkg::rsp_data_t),
    .Pass      (1'b1)
  ) u_rsp_fifo (
    .clk_i    (clk_i),
    .rst_ni   (rst_ni),
    .wvalid_i (rsp_wvalid),
    .wready_o (),
    .wdata_i  (rsp_wdata),
    .rvalid_o (rsp_valid_o),
    .rready_i (rsp_pop_i),
    .rdata_o  (rsp_o)
  );

endmodule

`default_nettype wire

//--- design/tl_rsp_gen.sv
////////////////////////////////////////////////////////////
// D-channel response assembly, error blanking, FIFO pops
////////////////////////////////////////////////////////////
`timescale 1ns/1ps
`default_nettype none

module tl_rsp_gen (
  // Request context head
  input  logic                                 ctx_valid_i,
  input  sram_adapter_pkg::req_ctx_t           ctx_i,
  output logic                                 ctx_pop_o,
  // Read data head
  input  logic                                 rsp_valid_i,
  input  sram_adapter_pkg::rsp_data_t          rsp_i,
  output logic                                 rsp_pop_o,
  // D channel
  output logic                                 d_valid_o,
  output logic [2:0]                           d_opcode_o,
  output logic [sram_adapter_pkg::TlSzw-1:0]   d_size_o,
  output logic [sram_adapter_pkg::TlAiw-1:0]   d_source_o,
  output logic [sram_adapter_pkg::TlDw-1:0]    d_data_o,
  output logic                                 d_error_o,
  input  logic                                 d_ready_i
);

  logic is_read, is_rd_op, rsp_err;
  logic [sram_adapter_pkg::TlDw-1:0] blank_data;

  assign is_rd_op = (ctx_i.op == sram_adapter_pkg::OpRead);

  // Errored reads never reached the SRAM, so no data is awaited
  assign is_read = is_rd_op & ~ctx_i.error;

  // Writes and errors respond at once while reads wait for data
  assign d_valid_o = ctx_valid_i & (~is_read | rsp_valid_i);

  assign rsp_err = ctx_i.error | (is_read & rsp_i.error);

  // Blanking depends on whether the access was a fetch
  assign blank_data = ctx_i.instr ? sram_adapter_pkg::DataWhenInstrError
                                  : sram_adapter_pkg::DataWhenError;

  // Outputs stay quiet while no response is presented
  always_comb begin
    d_opcode_o = sram_adapter_pkg::OpAccessAckData;
    d_size_o   = '0;
    d_source_o = '0;
    d_error_o  = 1'b0;
    d_data_o   = '0;
    if (d_valid_o) begin
      d_opcode_o = is_rd_op ? sram_adapter_pkg::OpAccessAckData
                            : sram_adapter_pkg::OpAccessAck;
      d_size_o   = ctx_i.size;
      d_source_o = ctx_i.source;
      d_error_o  = rsp_err;
      if (rsp_err) begin
        d_data_o = blank_data;
      end else if (is_read) begin
        d_data_o = rsp_i.data;
      end
      // Plain write acknowledge returns zero data
    end
  end

  // Context and read data retire together on the D handshake
  assign ctx_pop_o = d_valid_o & d_ready_i;
  assign rsp_pop_o = ctx_pop_o & is_read;

endmodule

`default_nettype wire

//--- design/tlul_sram_adapter.sv
////////////////////////////////////////////////////////////
// TL-UL to SRAM adapter top, intake, read data alignment
// and response generation
////////////////////////////////////////////////////////////
`timescale 1ns/1ps
`default_nettype none

module tlul_sram_adapter (
  input  logic                                clk_i,
  input  logic                                rst_ni,
  // A channel
  input  logic                                a_valid_i,
  input  logic [2:0]                          a_opcode_i,
  input  logic [sram_adapter_pkg::TlSzw-1:0]  a_size_i,
  input  logic [sram_adapter_pkg::TlDbw-1:0]  a_mask_i,
  input  logic [sram_adapter_pkg::TlAw-1:0]   a_address_i,
  input  logic [sram_adapter_pkg::TlAiw-1:0]  a_source_i,
  input  logic [sram_adapter_pkg::TlDw-1:0]   a_data_i,
  input  logic                                a_instr_i,
  output logic                                a_ready_o,
  // D channel
  output logic                                d_valid_o,
  output logic [2:0]                          d_opcode_o,
  output logic [sram_adapter_pkg::TlSzw-1:0]  d_size_o,
  output logic [sram_adapter_pkg::TlAiw-1:0]  d_source_o,
  output logic [sram_adapter_pkg::TlDw-1:0]   d_data_o,
  output logic                                d_error_o,
  input  logic                                d_ready_i,
  // Fetch enable
  input  logic                                en_ifetch_i,
  // SRAM
  output logic                                req_o,
  input  logic                                gnt_i,
  output logic                                we_o,
  output logic [sram_adapter_pkg::SramAw-1:0] addr_o,
  output logic [sram_adapter_pkg::SramDw-1:0] wdata_o,
  output logic [sram_adapter_pkg::SramDw-1:0] wmask_o,
  input  logic [sram_adapter_pkg::SramDw-1:0] rdata_i,
  input  logic                                rvalid_i,
  input  logic                                rerror_i
);

  // Request order context
  logic                           ctx_valid, ctx_pop;
  sram_adapter_pkg::req_ctx_t     ctx;
  // Pending read context
  logic                           rd_ctx_push, rd_ctx_ready;
  sram_adapter_pkg::sram_rd_ctx_t rd_ctx;
  // Aligned read data
  logic                           rsp_valid, rsp_pop;
  sram_adapter_pkg::rsp_data_t    rsp;

  tl_req_intake u_intake (
    .clk_i          (clk_i),
    .rst_ni         (rst_ni),
    .a_valid_i      (a_valid_i),
    .a_opcode_i     (a_opcode_i),
    .a_size_i       (a_size_i),
    .a_mask_i       (a_mask_i),
    .a_address_i    (a_address_i),
    .a_source_i     (a_source_i),
    .a_data_i       (a_data_i),
    .a_instr_i      (a_instr_i),
    .a_ready_o      (a_ready_o),
    .en_ifetch_i    (en_ifetch_i),
    .req_o          (req_o),
    .gnt_i          (gnt_i),
    .we_o           (we_o),
    .addr_o         (addr_o),
    .wdata_o        (wdata_o),
    .wmask_o        (wmask_o),
    .ctx_valid_o    (ctx_valid),
    .ctx_o          (ctx),
    .ctx_pop_i      (ctx_pop),
    .rd_ctx_push_o  (rd_ctx_push),
    .rd_ctx_o       (rd_ctx),
    .rd_ctx_ready_i (rd_ctx_ready)
  );

  sram_rdata_align u_align (
    .clk_i          (clk_i),
    .rst_ni         (rst_ni),
    .rd_ctx_push_i  (rd_ctx_push),
    .rd_ctx_i       (rd_ctx),
    .rd_ctx_ready_o (rd_ctx_ready),
    .rdata_i        (rdata_i),
    .rvalid_i       (rvalid_i),
    .rerror_i       (rerror_i),
    .rsp_valid_o    (rsp_valid),
    .rsp_o          (rsp),
    .rsp_pop_i      (rsp_pop)
  );

  tl_rsp_gen u_rsp_gen (
    .ctx_valid_i (ctx_valid),
    .ctx_i       (ctx),
    .ctx_pop_o   (ctx_pop),
    .rsp_valid_i (rsp_valid),
    .rsp_i       (rsp),
    .rsp_pop_o   (rsp_pop),
    .d_valid_o   (d_valid_o),
    .d_opcode_o  (d_opcode_o),
    .d_size_o    (d_size_o),
    .d_source_o  (d_source_o),
    .d_data_o    (d_data_o),
    .d_error_o   (d_error_o),
    .d_ready_i   (d_ready_i)
  );

endmodule

`default_nettype wire

//--- test/tlul_sram_adapter_props.sv
////////////////////////////////////////////////////////////
// Handshake assertions bound into the adapter top
////////////////////////////////////////////////////////////
`timescale 1ns/1ps
`default_nettype none

module tlul_sram_adapter_props (
  input logic        clk_i,
  input logic        rst_ni,
  input logic        a_valid_i,
  input logic        a_ready_i,
  input logic        a_instr_i,
  input logic        en_ifetch_i,
  input logic [2:0]  a_opcode_i,
  input logic [1:0]  a_size_i,
  input logic [31:0] a_address_i,
  input logic        req_i,
  input logic        rvalid_i,
  input logic        d_valid_i,
  input logic        d_ready_i,
  input logic [45:0] d_rsp_i
);

  int   rd_pending;
  int   unanswered;
  logic bad_req;
  logic rd_accept;

  // Request that must be refused before the SRAM
  assign bad_req = !(a_opcode_i inside {sram_adapter_pkg::OpGet, sram_adapter_pkg::OpPutFull,
                                        sram_adapter_pkg::OpPutPartial}) ||
                   (a_size_i > 2'd2) ||
                   (a_size_i == 2'd2 && a_address_i[1:0] != 2'b00) ||
                   (a_size_i == 2'd1 && a_address_i[0]) ||
                   (a_instr_i && !en_ifetch_i);

  // Valid Get taken on the A channel, so SRAM data is owed for it
  assign rd_accept = a_valid_i && a_ready_i && !bad_req &&
                     (a_opcode_i == sram_adapter_pkg::OpGet);

  always_ff @(posedge clk_i or negedge rst_ni) begin
    if (!rst_ni) begin
      rd_pending <= 0;
      unanswered <= 0;
    end else begin
      rd_pending <= rd_pending + int'(rd_accept) - int'(rvalid_i);
      unanswered <= unanswered + int'(a_valid_i & a_ready_i) - int'(d_valid_i & d_ready_i);
    end
  end

  stall_hold: assert property (@(posedge clk_i) disable iff (!rst_ni)
    d_valid_i && !d_ready_i |=> d_valid_i && $stable(d_rsp_i))
    else $error("D channel changed while stalled");

  rvalid_pending: assert property (@(posedge clk_i) disable iff (!rst_ni)
    rvalid_i |-> rd_pending > 0)
    else $error("SRAM read data without a pending read");

  req_clean: assert property (@(posedge clk_i) disable iff (!rst_ni)
    req_i |-> !bad_req)
    else $error("SRAM request raised for a refused access");

  within_limit: assert property (@(posedge clk_i) disable iff (!rst_ni)
    unanswered <= sram_adapter_pkg::Outstanding)
    else $error("Too many unanswered requests");

endmodule

bind tlul_sram_adapter tlul_sram_adapter_props props_inst (
  .clk_i       (clk_i),
  .rst_ni      (rst_ni),
  .a_valid_i   (a_valid_i),
  .a_ready_i   (a_ready_o),
  .a_instr_i   (a_instr_i),
  .en_ifetch_i (en_ifetch_i),
  .a_opcode_i  (a_opcode_i),
  .a_size_i    (a_size_i),
  .a_address_i (a_address_i),
  .req_i       (req_o),
  .rvalid_i    (rvalid_i),
  .d_valid_i   (d_valid_o),
  .d_ready_i   (d_ready_i),
  .d_rsp_i     ({d_opcode_o, d_size_o, d_source_o, d_data_o, d_error_o})
);

`default_nettype wire

//--- test/tb_checker.sv
////////////////////////////////////////////////////////////
// Response and SRAM write checker for the adapter testbench
////////////////////////////////////////////////////////////
`timescale 1ns/1ps
`default_nettype none

module tb_checker (
  input logic                                clk_i,
  input logic                                rst_ni,
  // D channel
  input logic                                d_valid_i,
  input logic                                d_ready_i,
  input logic                                d_error_i,
  input logic [2:0]                          d_opcode_i,
  input logic [sram_adapter_pkg::TlSzw-1:0]  d_size_i,
  input logic [sram_adapter_pkg::TlAiw-1:0]  d_source_i,
  input logic [sram_adapter_pkg::TlDw-1:0]   d_data_i,
  // SRAM write side and the request behind it
  input logic                                req_i,
  input logic                                gnt_i,
  input logic                                we_i,
  input logic [sram_adapter_pkg::SramAw-1:0] addr_i,
  input logic [sram_adapter_pkg::SramDw-1:0] wdata_i,
  input logic [sram_adapter_pkg::SramDw-1:0] wmask_i,
  input logic [sram_adapter_pkg::TlAw-1:0]   a_address_i,
  input logic [sram_adapter_pkg::TlDbw-1:0]  a_mask_i,
  input logic [sram_adapter_pkg::TlDw-1:0]   a_data_i
);

  // {opcode, size, source, data, error} in request order
  logic [45:0] exp_q [$];
  logic [45:0] got, exp_rsp;
  logic [63:0] lane_mask;
  int checked = 0;
  int errors  = 0;

  task push_expect(input logic [45:0] rsp);
    exp_q.push_back(rsp);
  endtask

  function int pending();
    return exp_q.size();
  endfunction

  always @(posedge clk_i) begin
    if (rst_ni && d_valid_i && d_ready_i) begin
      got = {d_opcode_i, d_size_i, d_source_i, d_data_i, d_error_i};
      if (exp_q.size() == 0) begin
        $display("Response for source %0d arrived with no request pending", d_source_i);
        errors++;
      end else begin
        exp_rsp = exp_q.pop_front();
        checked++;
        if (got !== exp_rsp) begin
          $display("FAILED %0t: got op %0h size %0d src %0d data %08h err %0b", $time,
                   got[45:43], got[42:41], got[40:33], got[32:1], got[0]);
          $display("FAILED %0t: exp op %0h size %0d src %0d data %08h err %0b", $time,
                   exp_rsp[45:43], exp_rsp[42:41], exp_rsp[40:33], exp_rsp[32:1], exp_rsp[0]);
          errors++;
        end
      end
    end
    // Write lanes follow address bit 2 and the byte mask
    if (rst_ni && req_i && gnt_i && we_i) begin
      lane_mask = '0;
      for (int b = 0; b < 4; b++) begin
        if (a_mask_i[b]) begin
          lane_mask[32*a_address_i[2] + 8*b +: 8] = 8'hff;
        end
      end
      if (wmask_i !== lane_mask || addr_i !== a_address_i[12:3] ||
          (wdata_i & lane_mask) !== ({2{a_data_i}} & lane_mask)) begin
        $display("FAILED %0t: SRAM write word %0h mask %016h data %016h, expected %0h mask %016h",
                 $time, addr_i, wmask_i, wdata_i, a_address_i[12:3], lane_mask);
        errors++;
      end
    end
  end

endmodule

`default_nettype wire

//--- test/tb_top.sv
////////////////////////////////////////////////////////////
// Testbench top with clock and reset, pattern driven requests,
// SRAM model with random stalls and the closing report
////////////////////////////////////////////////////////////
`timescale 1ns/1ps
`default_nettype none

module tb_top;

  localparam int MaxPat  = 32;
  localparam int Cols    = 9;
  localparam int WaitMax = 200;

  // DUT inputs start quiet at time zero
  logic                                clk_i       = 1'b0;
  logic                                rst_ni      = 1'b0;
  logic                                a_valid_i   = 1'b0;
  logic [2:0]                          a_opcode_i  = '0;
  logic [sram_adapter_pkg::TlSzw-1:0]  a_size_i    = '0;
  logic [sram_adapter_pkg::TlDbw-1:0]  a_mask_i    = '0;
  logic [sram_adapter_pkg::TlAw-1:0]   a_address_i = '0;
  logic [sram_adapter_pkg::TlAiw-1:0]  a_source_i  = '0;
  logic [sram_adapter_pkg::TlDw-1:0]   a_data_i    = '0;
  logic                                a_instr_i   = 1'b0;
  logic                                d_ready_i   = 1'b0;
  logic                                en_ifetch_i = 1'b0;
  logic                                gnt_i       = 1'b0;
  logic [sram_adapter_pkg::SramDw-1:0] rdata_i     = '0;
  logic                                rvalid_i    = 1'b0;
  logic                                rerror_i    = 1'b0;

  // DUT outputs
  logic                                a_ready_o, d_valid_o, d_error_o, req_o, we_o;
  logic [2:0]                          d_opcode_o;
  logic [sram_adapter_pkg::TlSzw-1:0]  d_size_o;
  logic [sram_adapter_pkg::TlAiw-1:0]  d_source_o;
  logic [sram_adapter_pkg::TlDw-1:0]   d_data_o;
  logic [sram_adapter_pkg::SramAw-1:0] addr_o;
  logic [sram_adapter_pkg::SramDw-1:0] wdata_o, wmask_o;

  // Pattern table with nine hex columns per request
  logic [31:0] pat [MaxPat*Cols];
  int          num_pat;
  int          timeouts = 0;
  logic        bad_file = 1'b0;
  logic        rd_err_inject = 1'b0;
  logic [2:0]  exp_op;
  logic [31:0] rng = 32'he84e;
  logic [sram_adapter_pkg::SramDw-1:0] mem [2**sram_adapter_pkg::SramAw];

  always #10 clk_i = ~clk_i;

  tlul_sram_adapter tlul_sram_adapter_inst (.*);

  tb_checker checker_inst (
    .clk_i       (clk_i),
    .rst_ni      (rst_ni),
    .d_valid_i   (d_valid_o),
    .d_ready_i   (d_ready_i),
    .d_error_i   (d_error_o),
    .d_opcode_i  (d_opcode_o),
    .d_size_i    (d_size_o),
    .d_source_i  (d_source_o),
    .d_data_i    (d_data_o),
    .req_i       (req_o),
    .gnt_i       (gnt_i),
    .we_i        (we_o),
    .addr_i      (addr_o),
    .wdata_i     (wdata_o),
    .wmask_i     (wmask_o),
    .a_address_i (a_address_i),
    .a_mask_i    (a_mask_i),
    .a_data_i    (a_data_i)
  );

  function automatic logic [31:0] xorshift32(input logic [31:0] s);
    logic [31:0] x;
    x = s;
    x = x ^ (x << 13);
    x = x ^ (x >> 17);
    x = x ^ (x << 5);
    return x;
  endfunction

  // SRAM model plus grant and D-ready stalls from one generator
  always @(posedge clk_i) begin
    rng = xorshift32(rng);
    gnt_i     <= (rng[1:0] != 2'd0);
    d_ready_i <= rng[8];
    // Granted reads come back one cycle later
    rvalid_i  <= req_o & gnt_i & ~we_o;
    rerror_i  <= req_o & gnt_i & ~we_o & rd_err_inject;
    if (req_o && gnt_i && !we_o) begin
      rdata_i <= mem[addr_o];
    end
    if (req_o && gnt_i && we_o) begin
      mem[addr_o] <= (mem[addr_o] & ~wmask_o) | (wdata_o & wmask_o);
    end
  end

  // Hold the request until the A-channel handshake
  task automatic wait_accept(input int idx);
    int n;
    n = 0;
    @(posedge clk_i);
    while (!(a_valid_i && a_ready_o)) begin
      if (n == WaitMax) begin
        $display("Timeout: request %0d was never accepted", idx);
        timeouts++;
        return;
      end
      n++;
      @(posedge clk_i);
    end
  endtask

  // All expected responses must come back
  task automatic wait_drain();
    int n;
    n = 0;
    while (checker_inst.pending() != 0) begin
      if (n == WaitMax) begin
        $display("Timeout: %0d responses never arrived", checker_inst.pending());
        timeouts++;
        return;
      end
      n++;
      @(posedge clk_i);
    end
  endtask

  initial begin
    for (int w = 0; w < 2**sram_adapter_pkg::SramAw; w++) begin
      mem[w] = '0;
    end
    $readmemh("test/tl_patterns.txt", pat);
    // Table ends at an opcode column of ff
    num_pat = 0;
    while (num_pat < MaxPat && pat[num_pat*Cols] != 32'hff) begin
      num_pat++;
    end
    if (num_pat == 0 || num_pat == MaxPat) begin
      $display("Pattern file is missing, empty or has no end marker");
      bad_file = 1'b1;
      num_pat  = 0;
    end
    repeat (10) @(posedge clk_i);
    rst_ni <= 1'b1;
    @(posedge clk_i);
    for (int p = 0; p < num_pat && timeouts == 0; p++) begin
      a_valid_i     <= 1'b1;
      a_opcode_i    <= pat[p*Cols][2:0];
      a_address_i   <= pat[p*Cols+1];
      a_data_i      <= pat[p*Cols+2];
      a_mask_i      <= pat[p*Cols+3][3:0];
      a_instr_i     <= pat[p*Cols+4][0];
      en_ifetch_i   <= pat[p*Cols+5][0];
      rd_err_inject <= pat[p*Cols+6][0];
      a_source_i    <= p[7:0];
      a_size_i      <= 2'd2;
      // Only Get answers with data and everything else is acknowledged
      exp_op = (pat[p*Cols][2:0] == sram_adapter_pkg::OpGet) ?
               sram_adapter_pkg::OpAccessAckData : sram_adapter_pkg::OpAccessAck;
      checker_inst.push_expect({exp_op, 2'd2, p[7:0], pat[p*Cols+8], pat[p*Cols+7][0]});
      wait_accept(p);
    end
    a_valid_i <= 1'b0;
    if (timeouts == 0) begin
      wait_drain();
    end
    $display("Responses checked: %0d of %0d, errors: %0d, timeouts: %0d",
             checker_inst.checked, num_pat, checker_inst.errors, timeouts);
    if (timeouts == 0 && !bad_file && checker_inst.errors == 0 &&
        checker_inst.checked == num_pat) begin
      $display("Simulation completed successfully");
    end else begin
      $display("Simulation failed");
    end
    $finish;
  end

endmodule

`default_nettype wire

//--- test/tl_patterns.txt
// opcode address data mask instr en_ifetch rd_err exp_err exp_data
// opcode 4 Get, 0 PutFull, 1 PutPartial; a line with opcode ff ends the table
0 00000100 11223344 f 0 0 0 0 00000000
4 00000100 00000000 f 0 0 0 0 11223344
0 00000104 aabbccdd f 0 0 0 0 00000000
4 00000100 00000000 f 0 0 0 0 11223344
1 00000104 55667788 6 0 0 0 0 00000000
4 00000104 00000000 f 0 0 0 0 aa6677dd
4 00000104 00000000 3 0 0 0 0 000077dd
4 00000104 00000000 c 0 0 0 0 aa660000
2 00000100 00000000 f 0 0 0 1 ffffffff
4 00000102 00000000 f 0 0 0 1 ffffffff
0 00000101 12345678 f 0 0 0 1 ffffffff
4 00000100 00000000 f 1 0 0 1 0badf00d
4 00000100 00000000 f 1 1 0 0 11223344
4 00000104 00000000 f 0 0 1 1 ffffffff
4 00000104 00000000 f 0 0 0 0 aa6677dd
0 00000ff8 cafef00d f 0 0 0 0 00000000
0 00001ffc deadbeef f 0 0 0 0 00000000
4 00001ffc 00000000 f 0 0 0 0 deadbeef
4 00000ff8 00000000 f 0 0 0 0 cafef00d
ff 00000000 00000000 0 0 0 0 0 00000000

//--- list.f
design/sram_adapter_pkg.sv
design/adapter_fifo.sv
design/tl_req_intake.sv
design/sram_rdata_align.sv
design/tl_rsp_gen.sv
design/tlul_sram_adapter.sv
test/tlul_sram_adapter_props.sv
test/tb_checker.sv
test/tb_top.sv

//--- run.sh
#!/usr/bin/env bash
# Build and run the TL-UL SRAM adapter testbench with Verilator

cd "$(dirname "$0")" || exit 1
LOG=sim.log

verilator --binary --timing --assert -Wno-fatal -f list.f --top-module tb_top -o Vtb_top
if [ $? -ne 0 ]; then
  echo "Verilator build failed"
  exit 1
fi

./obj_dir/Vtb_top > "$LOG" 2>&1
status=$?
cat "$LOG"
if [ $status -ne 0 ]; then
  echo "Simulation run exited with status $status"
  exit 1
fi

if grep -q "Simulation completed successfully" "$LOG"; then
  exit 0
fi
exit 1
